// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = rv_core_tb
FILELIST   = rv_core.f
OBJ_DIR    = obj_dir
PASS_MSG   = Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== instr_queue.sv ====
`default_nettype none

`include "rv_core_defines.svh"

module instr_queue
    import rv_core_pkg::*;
(
    input  logic  CLK,
    input  logic  reset,
    // Write side from the receiver
    input  logic  push,
    input  word_t push_data,
    output logic  full,
    // Read side to the pipeline
    input  logic  pop,
    output word_t head_data,
    output logic  empty
);

    // Index of the last entry where the pointers wrap
    localparam logic [`RV_QUEUE_PTR_W-1:0] LAST_IDX = `RV_QUEUE_PTR_W'(`RV_QUEUE_DEPTH - 1);

    // Circular buffer storage
    word_t mem [`RV_QUEUE_DEPTH];

    logic [`RV_QUEUE_PTR_W-1:0] wr_ptr;
    logic [`RV_QUEUE_PTR_W-1:0] rd_ptr;
    logic [`RV_QUEUE_PTR_W:0]   count;

    // Qualified requests
    logic do_push;
    logic do_pop;

    assign full  = (count == (`RV_QUEUE_PTR_W+1)'(`RV_QUEUE_DEPTH));
    assign empty = (count == '0);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Show-ahead head is valid whenever empty is low
    assign head_data = mem[rd_ptr];

    // --------------------
    // Storage write
    // --------------------
    always_ff @(posedge CLK)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            // Simultaneous push and pop leave the count unchanged
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== instr_receiver.sv ====
`default_nettype none

module instr_receiver
    import rv_core_pkg::*;
(
    input  logic  CLK,
    input  logic  reset,
    // Four-phase slave side
    input  logic  instr_req,
    input  word_t instr_data,
    output logic  instr_ack,
    // Queue write side
    input  logic  full,
    output logic  push,
    output word_t push_data
);

    // Handshake state is high once the word is acknowledged
    logic acked;

    // Accept a new word only from idle, and only with room in the queue
    assign push = instr_req && !acked && !full;

    // Word is stable while req is high and goes to the queue as presented
    assign push_data = instr_data;

    assign instr_ack = acked;

    // --------------------
    // Handshake FSM
    // --------------------
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            acked <= 1'b0;
        end
        else if (!acked)
        begin
            // Raise ack from idle on the same edge as the push
            if (push)
                acked <= 1'b1;
        end
        else
        begin
            // Release ack only once the producer drops req
            if (!instr_req)
                acked <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rv_core.f ====
+incdir+.
rv_core_pkg.sv
instr_receiver.sv
instr_queue.sv
rv_decoder.sv
rv_execute_pipe.sv
rv_core.sv
rv_core_chk.sv
rv_core_tb.sv

// ==== rv_core.sv ====
`default_nettype none

module rv_core
    import rv_core_pkg::*;
(
    input  logic     CLK,
    input  logic     reset,
    // Four-phase instruction input
    input  logic     instr_req,
    input  word_t    instr_data,
    output logic     instr_ack,
    // Retire port
    output logic     retire_valid,
    output logic     retire_we,
    output reg_idx_t retire_rd,
    output word_t    retire_data
);

    // Receiver to queue
    logic  push;
    word_t push_data;
    logic  full;

    // Queue to pipeline
    logic  pop;
    word_t head_data;
    logic  empty;

    // --------------------
    // Input side
    // --------------------
    instr_receiver i_instr_receiver (
        .CLK        (CLK),
        .reset      (reset),
        .instr_req  (instr_req),
        .instr_data (instr_data),
        .instr_ack  (instr_ack),
        .full       (full),
        .push       (push),
        .push_data  (push_data)
    );

    instr_queue i_instr_queue (
        .CLK       (CLK),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .pop       (pop),
        .head_data (head_data),
        .empty     (empty)
    );

    // --------------------
    // Execution pipeline
    // --------------------
    rv_execute_pipe i_rv_execute_pipe (
        .CLK          (CLK),
        .reset        (reset),
        .head_data    (head_data),
        .empty        (empty),
        .pop          (pop),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

`default_nettype wire

// ==== rv_core_chk.sv ====
`default_nettype none

module rv_core_chk
    import rv_core_pkg::*;
(
    input logic     CLK,
    input logic     reset,
    input logic     instr_req,
    input logic     instr_ack,
    input logic     retire_valid,
    input logic     retire_we,
    input reg_idx_t retire_rd
);

    // --------------------
    // Four-phase handshake
    // --------------------

    // Ack only goes up in answer to a pending request
    ack_rise_on_req: assert property (@(posedge CLK) disable iff (reset)
        $rose(instr_ack) |-> $past(instr_req))
        else $error("instr_ack rose while instr_req was low");

    // Ack is released only once the request has been dropped
    ack_fall_after_req: assert property (@(posedge CLK) disable iff (reset)
        $fell(instr_ack) |-> !$past(instr_req))
        else $error("instr_ack fell while instr_req was still high");

    // --------------------
    // Retire port
    // --------------------

    // A register write needs a valid retirement and a real destination
    we_needs_valid_rd: assert property (@(posedge CLK) disable iff (reset)
        retire_we |-> (retire_valid && retire_rd != '0))
        else $error("retire_we high without retire_valid or with rd x0");

    // Outputs quiet right after a reset edge
    quiet_after_reset: assert property (@(posedge CLK)
        reset |=> (!instr_ack && !retire_valid))
        else $error("instr_ack or retire_valid high after reset");

endmodule

`default_nettype wire

// ==== rv_core_defines.svh ====
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// --------------------
// Instruction queue sizing
// --------------------

// Number of instruction words the queue can hold
`define RV_QUEUE_DEPTH 4

// Read and write pointer width, log2 of the depth
`define RV_QUEUE_PTR_W 2

// Occupancy count needs one bit more than a pointer
// so that a full queue can be told apart from an empty one

`endif

// ==== rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    // --------------------
    // Basic data types
    // --------------------

    // Instruction or data word
    typedef logic [31:0] word_t;

    // Register file index, x0 to x31
    typedef logic [4:0] reg_idx_t;

    // --------------------
    // Major opcodes
    // --------------------

    // Only the three supported major opcodes are named;
    // anything else decodes as illegal
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // --------------------
    // ALU operations
    // --------------------

    // One code per arithmetic, logic, compare and shift function
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        // Second operand straight through, used by LUI
        ALU_PASS_B = 4'd10
    } alu_op_e;

endpackage

`default_nettype wire

// ==== rv_core_tb.sv ====
`default_nettype none

module rv_core_tb
    import rv_core_pkg::*;
;

    // Instructions sent per test summed for the run limit
    localparam int N_SENT = 1 + 11 + 13 + 6 + 4 + 200;
    localparam int TIMEOUT_CYCLES = 10 * N_SENT + 50;

    logic     CLK = 1'b0;
    logic     reset;
    logic     instr_req;
    word_t    instr_data;
    logic     instr_ack;
    logic     retire_valid;
    logic     retire_we;
    reg_idx_t retire_rd;
    word_t    retire_data;

    // Reference register file and expected retirements in order
    word_t    model_rf [32];
    logic     exp_we_q [$];
    reg_idx_t exp_rd_q [$];
    word_t    exp_data_q [$];

    string    cur_test = "reset";
    int       errors = 0;
    int       test_err_start = 0;
    int       tests_ok = 0;
    int       tests_bad = 0;
    int       sent_count = 0;
    int       retire_count = 0;
    int       cycle_count = 0;
    word_t    rng_state = 32'h171a4d35;

    rv_core i_rv_core (
        .CLK          (CLK),
        .reset        (reset),
        .instr_req    (instr_req),
        .instr_data   (instr_data),
        .instr_ack    (instr_ack),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    bind rv_core rv_core_chk i_rv_core_chk (
        .CLK          (CLK),
        .reset        (reset),
        .instr_req    (instr_req),
        .instr_ack    (instr_ack),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd)
    );

    always #50 CLK = ~CLK;

    // Run limit
    always @(posedge CLK)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, DUT stopped making progress", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act)
        begin
            $display("mismatch in %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act)
        begin
            $display("mismatch in %s: expected x%0d, actual x%0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("mismatch in %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    // --------------------
    // Encoding and reference model
    // --------------------
    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic word_t xorshift32();
        word_t x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // RV32I result by funct3 where alt selects SUB or SRA
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0:
                if (alt)
                    return a - b;
                else
                    return a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5:
                if (alt)
                    return word_t'($signed(a) >>> b[4:0]);
                else
                    return a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Apply one instruction to the model and queue its retirement
    task automatic predict(input word_t instr);
        logic [2:0] f3;
        logic [6:0] f7;
        reg_idx_t   rd;
        logic       legal;
        logic       we;
        word_t      val;
        f3 = instr[14:12];
        f7 = instr[31:25];
        rd = instr[11:7];
        legal = 1'b0;
        val = '0;
        if (instr[6:0] == OPC_OP)
        begin
            legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            val = alu_ref(f3, f7[5], model_rf[instr[19:15]], model_rf[instr[24:20]]);
        end
        else if (instr[6:0] == OPC_OP_IMM)
        begin
            // Shift immediates constrain the upper bits
            if (f3 == 3'd1)
                legal = (f7 == 7'h00);
            else if (f3 == 3'd5)
                legal = (f7 == 7'h00) || (f7 == 7'h20);
            else
                legal = 1'b1;
            val = alu_ref(f3, (f3 == 3'd5) && f7[5], model_rf[instr[19:15]],
                          {{20{instr[31]}}, instr[31:20]});
        end
        else if (instr[6:0] == OPC_LUI)
        begin
            legal = 1'b1;
            val = {instr[31:12], 12'b0};
        end
        we = legal && (rd != 5'd0);
        if (we)
            model_rf[rd] = val;
        exp_we_q.push_back(we);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(val);
    endtask

    // --------------------
    // Stimulus and monitor
    // --------------------

    // One four-phase transfer started on a falling edge
    task automatic send_instr(input word_t instr);
        predict(instr);
        sent_count++;
        instr_data = instr;
        instr_req = 1'b1;
        @(negedge CLK);
        while (instr_ack !== 1'b1)
            @(negedge CLK);
        instr_req = 1'b0;
        @(negedge CLK);
        while (instr_ack !== 1'b0)
            @(negedge CLK);
    endtask

    // Retire outputs come from registers and are stable at the falling edge
    always @(negedge CLK)
    begin
        logic     e_we;
        reg_idx_t e_rd;
        word_t    e_data;
        if (!reset && retire_valid === 1'b1)
        begin
            retire_count++;
            if (exp_we_q.size() == 0)
            begin
                $display("%s: retirement of x%0d with no instruction outstanding",
                         cur_test, retire_rd);
                errors++;
            end
            else
            begin
                e_we = exp_we_q.pop_front();
                e_rd = exp_rd_q.pop_front();
                e_data = exp_data_q.pop_front();
                check_bit(cur_test, e_we, retire_we);
                check_idx(cur_test, e_rd, retire_rd);
                // Data only matters when a register is written
                if (e_we)
                    check_word(cur_test, e_data, retire_data);
            end
        end
    end

    task automatic wait_drain();
        while (exp_we_q.size() != 0)
            @(negedge CLK);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        wait_drain();
        $display("test %-10s %0d errors", cur_test, errors - test_err_start);
        if (errors == test_err_start)
            tests_ok++;
        else
            tests_bad++;
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset_addi();
        begin_test("reset_addi");
        check_bit(cur_test, 1'b0, instr_ack);
        check_bit(cur_test, 1'b0, retire_valid);
        send_instr(enc_i(12'h5a5, 5'd0, 3'd0, 5'd1));
        end_test();
    endtask

    task automatic test_op_imm();
        begin_test("op_imm");
        send_instr(enc_i(12'hff9, 5'd0, 3'd0, 5'd2));
        send_instr(enc_i(12'h123, 5'd0, 3'd0, 5'd3));
        // Signed and unsigned compares against a negative source
        send_instr(enc_i(12'hffd, 5'd2, 3'd2, 5'd4));
        send_instr(enc_i(12'h005, 5'd2, 3'd3, 5'd5));
        send_instr(enc_i(12'h0f0, 5'd3, 3'd4, 5'd6));
        send_instr(enc_i(12'h800, 5'd3, 3'd6, 5'd7));
        send_instr(enc_i(12'h7f0, 5'd2, 3'd7, 5'd8));
        send_instr(enc_i(12'h007, 5'd3, 3'd1, 5'd9));
        send_instr(enc_i(12'h004, 5'd2, 3'd5, 5'd10));
        send_instr(enc_i(12'h402, 5'd2, 3'd5, 5'd11));
        send_instr(enc_i(12'hfff, 5'd3, 3'd3, 5'd12));
        end_test();
    endtask

    // Each result feeds the next as closely as the handshake allows
    task automatic test_op_forward();
        begin_test("op_forward");
        send_instr(enc_i(12'd100, 5'd0, 3'd0, 5'd1));
        send_instr(enc_i(12'hfdb, 5'd0, 3'd0, 5'd2));
        send_instr(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        send_instr(enc_r(7'h20, 5'd1, 5'd3, 3'd0, 5'd4));
        send_instr(enc_r(7'h00, 5'd1, 5'd4, 3'd1, 5'd5));
        send_instr(enc_r(7'h00, 5'd3, 5'd2, 3'd2, 5'd6));
        send_instr(enc_r(7'h00, 5'd3, 5'd2, 3'd3, 5'd7));
        send_instr(enc_r(7'h00, 5'd2, 5'd5, 3'd4, 5'd8));
        send_instr(enc_r(7'h00, 5'd1, 5'd2, 3'd5, 5'd9));
        send_instr(enc_r(7'h20, 5'd1, 5'd2, 3'd5, 5'd10));
        send_instr(enc_r(7'h00, 5'd9, 5'd10, 3'd6, 5'd11));
        send_instr(enc_r(7'h00, 5'd8, 5'd11, 3'd7, 5'd12));
        send_instr(enc_r(7'h00, 5'd12, 5'd12, 3'd0, 5'd12));
        end_test();
    endtask

    task automatic test_lui_x0();
        begin_test("lui_x0");
        send_instr(enc_u(20'habcde, 5'd13));
        send_instr(enc_i(12'h123, 5'd13, 3'd0, 5'd13));
        send_instr(enc_i(12'd55, 5'd0, 3'd0, 5'd0));
        send_instr(enc_r(7'h00, 5'd13, 5'd0, 3'd0, 5'd14));
        send_instr(enc_u(20'h12345, 5'd0));
        send_instr(enc_r(7'h00, 5'd0, 5'd0, 3'd6, 5'd15));
        end_test();
    endtask

    task automatic test_illegal();
        begin_test("illegal");
        // Load, multiply and a shift with a bad funct7
        send_instr({12'h004, 5'd0, 3'b010, 5'd1, 7'b0000011});
        send_instr(enc_r(7'h01, 5'd1, 5'd1, 3'd0, 5'd2));
        send_instr(enc_i(12'h403, 5'd1, 3'd1, 5'd3));
        send_instr(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd16));
        end_test();
    endtask

    task automatic test_random();
        word_t      r;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        int         start_retired;
        int         start_sent;
        begin_test("random");
        start_retired = retire_count;
        start_sent = sent_count;
        for (int i = 0; i < 200; i++)
        begin
            r = xorshift32();
            f3 = r[2:0];
            rd = {2'b00, r[14:12]};
            rs1 = {2'b00, r[11:9]};
            rs2 = {2'b00, r[8:6]};
            // Alternate funct7 only where the ISA defines it
            f7 = (r[5] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
            case (r[4:3])
                2'd0, 2'd1: send_instr(enc_r(f7, rs2, rs1, f3, rd));
                2'd2:
                begin
                    if (f3 == 3'd1 || f3 == 3'd5)
                        imm = {f7, r[20:16]};
                    else
                        imm = r[31:20];
                    send_instr(enc_i(imm, rs1, f3, rd));
                end
                default: send_instr(enc_u(r[31:12], rd));
            endcase
        end
        wait_drain();
        // Stay past the pipeline depth so a late extra retirement is counted
        repeat (4)
            @(negedge CLK);
        if (retire_count - start_retired != sent_count - start_sent)
        begin
            $display("random: %0d retirements seen for %0d instructions sent",
                     retire_count - start_retired, sent_count - start_sent);
            errors++;
        end
        end_test();
    endtask

    initial
    begin
        for (int i = 0; i < 32; i++)
            model_rf[i] = '0;
        reset = 1'b1;
        instr_req = 1'b0;
        instr_data = '0;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        reset = 1'b0;
        test_reset_addi();
        test_op_imm();
        test_op_forward();
        test_lui_x0();
        test_illegal();
        test_random();
        $display("summary: %0d tests clean, %0d tests with errors, %0d errors total",
                 tests_ok, tests_bad, errors);
        if (tests_bad == 0 && errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_decoder.sv ====
`default_nettype none

module rv_decoder
    import rv_core_pkg::*;
(
    input  word_t    instr,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output word_t    imm,
    output alu_op_e  alu_op,
    output logic     use_imm,
    output logic     writes_rd
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    // funct7 is all zero, or the SUB / SRA pattern
    logic       f7_norm;
    logic       f7_alt;
    logic       legal;
    word_t      imm_i;
    word_t      imm_u;

    // --------------------
    // Field extraction
    // --------------------
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    assign f7_norm = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    // I-type is sign extended, U-type fills the upper 20 bits
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    // --------------------
    // Operation select
    // --------------------
    always_comb
    begin
        alu_op  = ALU_ADD;
        use_imm = 1'b0;
        imm     = imm_i;
        legal   = 1'b0;
        case (opcode_e'(instr[6:0]))
            OPC_OP:
            begin
                case (funct3)
                    3'b000:  alu_op = f7_alt ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_op = ALU_SLL;
                    3'b010:  alu_op = ALU_SLT;
                    3'b011:  alu_op = ALU_SLTU;
                    3'b100:  alu_op = ALU_XOR;
                    3'b101:  alu_op = f7_alt ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
                // Alternate funct7 only exists for SUB and SRA
                legal = f7_norm || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_OP_IMM:
            begin
                use_imm = 1'b1;
                case (funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b001:  alu_op = ALU_SLL;
                    3'b010:  alu_op = ALU_SLT;
                    3'b011:  alu_op = ALU_SLTU;
                    3'b100:  alu_op = ALU_XOR;
                    3'b101:  alu_op = f7_alt ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
                // Upper immediate bits are only constrained for the shifts
                if (funct3 == 3'b001)
                    legal = f7_norm;
                else if (funct3 == 3'b101)
                    legal = f7_norm || f7_alt;
                else
                    legal = 1'b1;
            end
            OPC_LUI:
            begin
                alu_op  = ALU_PASS_B;
                use_imm = 1'b1;
                imm     = imm_u;
                legal   = 1'b1;
            end
            default:
            begin
                legal = 1'b0;
            end
        endcase
    end

    // x0 is never written, so illegal and x0 targets look the same
    assign writes_rd = legal && (rd != '0);

endmodule

`default_nettype wire

// ==== rv_execute_pipe.sv ====
`default_nettype none

module rv_execute_pipe
    import rv_core_pkg::*;
(
    input  logic     CLK,
    input  logic     reset,
    // Queue read side
    input  word_t    head_data,
    input  logic     empty,
    output logic     pop,
    // Retire port with one retirement per cycle and no back-pressure
    output logic     retire_valid,
    output logic     retire_we,
    output reg_idx_t retire_rd,
    output word_t    retire_data
);

    // Register file where x0 is never written and stays zero
    word_t rf [32];

    // Decode stage
    logic     dec_valid;
    word_t    dec_instr;
    reg_idx_t dec_rs1;
    reg_idx_t dec_rs2;
    reg_idx_t dec_rd;
    word_t    dec_imm;
    alu_op_e  dec_alu_op;
    logic     dec_use_imm;
    logic     dec_writes_rd;
    word_t    dec_src1;
    word_t    dec_src2;

    // Execute stage
    logic     ex_valid;
    logic     ex_we;
    reg_idx_t ex_rd;
    alu_op_e  ex_alu_op;
    word_t    ex_a;
    word_t    ex_b;
    word_t    ex_result;

    // Write-back stage
    logic     wb_valid;
    logic     wb_we;
    reg_idx_t wb_rd;
    word_t    wb_data;

    // Forwarded read where the youngest producer wins over the register file
    function automatic word_t read_operand(input reg_idx_t idx);
        if (ex_we && ex_rd == idx)
            return ex_result;
        else if (wb_we && wb_rd == idx)
            return wb_data;
        else
            return rf[idx];
    endfunction

    // Never stalls, so take a word every cycle one is there
    assign pop = !empty;

    // --------------------
    // Decode stage
    // --------------------
    rv_decoder i_rv_decoder (
        .instr     (dec_instr),
        .rs1       (dec_rs1),
        .rs2       (dec_rs2),
        .rd        (dec_rd),
        .imm       (dec_imm),
        .alu_op    (dec_alu_op),
        .use_imm   (dec_use_imm),
        .writes_rd (dec_writes_rd)
    );

    assign dec_src1 = read_operand(dec_rs1);
    assign dec_src2 = dec_use_imm ? dec_imm : read_operand(dec_rs2);

    // --------------------
    // Execute stage ALU
    // --------------------
    always_comb
    begin
        case (ex_alu_op)
            ALU_SUB:    ex_result = ex_a - ex_b;
            ALU_SLL:    ex_result = ex_a << ex_b[4:0];
            ALU_SLT:    ex_result = word_t'($signed(ex_a) < $signed(ex_b));
            ALU_SLTU:   ex_result = word_t'(ex_a < ex_b);
            ALU_XOR:    ex_result = ex_a ^ ex_b;
            ALU_SRL:    ex_result = ex_a >> ex_b[4:0];
            ALU_SRA:    ex_result = word_t'($signed(ex_a) >>> ex_b[4:0]);
            ALU_OR:     ex_result = ex_a | ex_b;
            ALU_AND:    ex_result = ex_a & ex_b;
            ALU_PASS_B: ex_result = ex_b;
            default:    ex_result = ex_a + ex_b;
        endcase
    end

    // --------------------
    // Stage registers
    // --------------------
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            dec_valid <= 1'b0;
            ex_valid  <= 1'b0;
            ex_we     <= 1'b0;
            wb_valid  <= 1'b0;
            wb_we     <= 1'b0;
        end
        else
        begin
            dec_valid <= pop;
            ex_valid  <= dec_valid;
            ex_we     <= dec_valid && dec_writes_rd;
            wb_valid  <= ex_valid;
            wb_we     <= ex_we;
        end
    end

    // Payload follows the valid bits
    always_ff @(posedge CLK)
    begin
        dec_instr <= head_data;
        ex_rd     <= dec_rd;
        ex_alu_op <= dec_alu_op;
        ex_a      <= dec_src1;
        ex_b      <= dec_src2;
        wb_rd     <= ex_rd;
        wb_data   <= ex_result;
    end

    // --------------------
    // Register file write
    // --------------------
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                rf[i] <= '0;
        end
        else if (wb_we)
        begin
            rf[wb_rd] <= wb_data;
        end
    end

    // Retire straight from the write-back stage
    assign retire_valid = wb_valid;
    assign retire_we    = wb_we;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

`default_nettype wire
